//--- hdl/core_settings.svh
// Shared widths, depths, opcode and redirect codes; include in any file that needs them
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define WORD_W      16        // Data word and PC width
`define REG_ADDR_W  3         // Eight registers
`define MEM_WORDS   256       // Data memory and stack share it
`define SP_RESET    255       // Stack grows down from the top
`define IN_CREDITS  4         // Input FIFO depth
`define OUT_CREDITS 2         // Output credits after reset
`define INT_VECTOR  16'h0010  // Interrupt handler address

`define OP_NOP   4'd0
`define OP_FLAG  4'd1         // CLRC / SETC
`define OP_ALU   4'd2         // NOT INC DEC MOV ADD SUB AND OR
`define OP_OUT   4'd3
`define OP_IN    4'd4
`define OP_SHIFT 4'd5         // SHL SHR LDM
`define OP_PUSH  4'd6
`define OP_POP   4'd7
`define OP_JMP   4'd8         // JMP JN JC JZ
`define OP_CALL  4'd9
`define OP_RET   4'd10
`define OP_LDD   4'd11
`define OP_STD   4'd12
`define OP_RETI  4'd14

`define RD_JUMP  3'd0
`define RD_CALL  3'd1
`define RD_RET   3'd2
`define RD_RETI  3'd3
`define RD_INT   3'd4

`endif

//--- hdl/corePkg.sv
// Vector types for the core; imported by the RTL stages and the testbench
`include "core_settings.svh"

package corePkg;

  // One data word, also used for PCs and immediates
  typedef logic [`WORD_W-1:0] wordT;

  // Register number, rd or rs
  typedef logic [`REG_ADDR_W-1:0] regIdxT;

  // Major opcode
  typedef logic [3:0] opcodeT;

  // Variant within an opcode group
  typedef logic [2:0] funcT;

  // Flags packed as {Z, N, C}
  typedef logic [2:0] flagsT;

  // Data memory address, low bits of a word
  typedef logic [$clog2(`MEM_WORDS)-1:0] memAddrT;

  // Redirect report kind
  typedef logic [2:0] rdKindT;

  // Credit counter, wide enough for the input FIFO too
  typedef logic [2:0] creditT;

endpackage

//--- hdl/instrDecode.sv
// Decode stage: credit FIFO for incoming beats, control table, register file with forwarding
`include "core_settings.svh"

module instrDecode (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,
  input  corePkg::opcodeT instrOp,
  input  corePkg::funcT   instrFunc,
  input  corePkg::regIdxT instrRd,
  input  corePkg::regIdxT instrRs,
  input  corePkg::wordT   instrImm,
  input  corePkg::wordT   instrPc,
  input  logic            instrIrq,
  input  logic            hold,
  input  logic            wbEn,
  input  corePkg::regIdxT wbIdx,
  input  corePkg::wordT   wbData,
  input  logic            exRegWrite,
  input  logic            exMemToReg,
  input  corePkg::regIdxT exRd,
  input  corePkg::wordT   exValue,
  output logic            instrCredit,
  output logic            decValid,
  output corePkg::funcT   decFunc,
  output corePkg::regIdxT decRd,
  output corePkg::wordT   decA,
  output corePkg::wordT   decB,
  output corePkg::wordT   decImm,
  output corePkg::wordT   decPc,
  output logic            aluOp,
  output logic            aluSrc,
  output logic            regWrite,
  output logic            memRead,
  output logic            memWrite,
  output logic            memToReg,
  output logic            branch,
  output logic            outEn,
  output logic            inEn,
  output logic            push,
  output logic            pop,
  output logic            pushPc,
  output logic            popPc,
  output logic            isInt,
  output logic            isReti
);
  import corePkg::*;

  localparam int PtrW = $clog2(`IN_CREDITS);

  // FIFO storage, one field array per beat field
  opcodeT          fOp   [`IN_CREDITS];
  funcT            fFunc [`IN_CREDITS];
  regIdxT          fRd   [`IN_CREDITS];
  regIdxT          fRs   [`IN_CREDITS];
  wordT            fImm  [`IN_CREDITS];
  wordT            fPc   [`IN_CREDITS];
  logic            fIrq  [`IN_CREDITS];
  logic [PtrW-1:0] wrPtr, rdPtr;
  creditT          count;

  wordT   regs [8];                        // Register file, no reset
  logic   headValid, stall, popNow;
  logic [14:0] ctl;                        // Control bits of the head beat
  wordT   opA, opB;

  assign headValid = (count != '0);
  // Head needs the value a load in execute has not fetched yet
  assign stall  = headValid && exMemToReg && (exRd == fRd[rdPtr] || exRd == fRs[rdPtr]);
  assign popNow = headValid && !hold && !stall;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      instrCredit <= 1'b0;
    end else begin
      if (instrValid) wrPtr <= wrPtr + 1'b1;       // Sender holds a credit
      if (popNow) rdPtr <= rdPtr + 1'b1;
      count       <= count + creditT'(instrValid) - creditT'(popNow);
      instrCredit <= popNow;                       // Credit back a cycle later
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      fOp[wrPtr]   <= instrOp;
      fFunc[wrPtr] <= instrFunc;
      fRd[wrPtr]   <= instrRd;
      fRs[wrPtr]   <= instrRs;
      fImm[wrPtr]  <= instrImm;
      fPc[wrPtr]   <= instrPc;
      fIrq[wrPtr]  <= instrIrq;
    end
  end

  // Opcode table, irq overrides the opcode
  // Order: aluOp aluSrc regWrite memRead memWrite memToReg branch outEn inEn
  //        push pop pushPc popPc isInt isReti
  always_comb begin
    ctl = '0;
    if (fIrq[rdPtr]) begin
      ctl = 15'b000_010_100_101_010;              // Push pc, branch to vector
    end else begin
      case (fOp[rdPtr])
        `OP_FLAG:  ctl = 15'b100_000_000_000_000;
        `OP_ALU:   ctl = 15'b101_000_000_000_000;
        `OP_OUT:   ctl = 15'b000_000_010_000_000;
        `OP_IN:    ctl = 15'b001_000_001_000_000;
        `OP_SHIFT: ctl = 15'b011_000_000_000_000;
        `OP_PUSH:  ctl = 15'b000_010_000_100_000;
        `OP_POP:   ctl = 15'b001_101_000_010_000;
        `OP_JMP:   ctl = 15'b000_000_100_000_000;
        `OP_CALL:  ctl = 15'b000_010_100_101_000;
        `OP_RET:   ctl = 15'b000_100_000_010_100;
        `OP_LDD:   ctl = 15'b001_101_000_000_000;
        `OP_STD:   ctl = 15'b000_010_000_000_000;
        `OP_RETI:  ctl = 15'b000_100_000_010_101;
        default:   ctl = '0;                       // NOP and unused codes
      endcase
    end
  end

  // Operand read, execute result first, then writeback
  always_comb begin
    opA = regs[fRd[rdPtr]];
    if (wbEn && wbIdx == fRd[rdPtr]) opA = wbData;
    if (exRegWrite && exRd == fRd[rdPtr]) opA = exValue;
    opB = regs[fRs[rdPtr]];
    if (wbEn && wbIdx == fRs[rdPtr]) opB = wbData;
    if (exRegWrite && exRd == fRs[rdPtr]) opB = exValue;
  end

  always_ff @(posedge clk) begin
    if (wbEn) regs[wbIdx] <= wbData;               // Already gated by hold
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid <= 1'b0;
      {aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch, outEn, inEn,
       push, pop, pushPc, popPc, isInt, isReti} <= '0;
    end else if (!hold) begin
      decValid <= popNow;                          // Bubble on stall
      {aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch, outEn, inEn,
       push, pop, pushPc, popPc, isInt, isReti} <= popNow ? ctl : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin                               // Payload, no reset
      decFunc <= fFunc[rdPtr];
      decRd   <= fRd[rdPtr];
      decA    <= opA;
      decB    <= opB;
      decImm  <= fImm[rdPtr];
      decPc   <= fPc[rdPtr];
    end
  end

endmodule

//--- hdl/aluExecute.sv
// Execute stage with ALU, shifter, flag register, jump resolution and push value; used by coreTop
`include "core_settings.svh"

module aluExecute (
  input  logic            clk,
  input  logic            rstN,
  input  logic            hold,
  input  corePkg::wordT   inPort,
  input  logic            decValid,
  input  corePkg::funcT   decFunc,
  input  corePkg::regIdxT decRd,
  input  corePkg::wordT   decA,
  input  corePkg::wordT   decB,
  input  corePkg::wordT   decImm,
  input  corePkg::wordT   decPc,
  input  logic            aluOp,
  input  logic            aluSrc,
  input  logic            regWrite,
  input  logic            memRead,
  input  logic            memWrite,
  input  logic            memToReg,
  input  logic            branch,
  input  logic            outEn,
  input  logic            inEn,
  input  logic            push,
  input  logic            pop,
  input  logic            pushPc,
  input  logic            popPc,
  input  logic            isInt,
  input  logic            isReti,
  output logic            exValid,
  output corePkg::regIdxT exRd,
  output corePkg::wordT   exValue,
  output corePkg::wordT   exStore,
  output corePkg::wordT   exTarget,
  output logic            exTaken,
  output logic            exRegWrite,
  output logic            exMemRead,
  output logic            exMemWrite,
  output logic            exMemToReg,
  output logic            exOutEn,
  output logic            exPush,
  output logic            exPop,
  output logic            exPushPc,
  output logic            exPopPc,
  output logic            exIsInt,
  output logic            exIsReti
);
  import corePkg::*;

  localparam int FZ = 2;             // Flag bit positions
  localparam int FN = 1;
  localparam int FC = 0;

  flagsT       flags, nextFlags;
  wordT        aluRes;
  logic [16:0] wide;                  // Carry or borrow in bit 16
  logic        cond;

  always_comb begin
    aluRes    = decB;
    wide      = '0;
    nextFlags = flags;
    if (aluOp && regWrite) begin                   // Register group
      case (decFunc)
        3'd0: aluRes = ~decB;
        3'd1: begin
          wide   = {1'b0, decB} + 17'd1;
          aluRes = wide[15:0];
        end
        3'd2: begin
          wide   = {1'b0, decB} - 17'd1;
          aluRes = wide[15:0];
        end
        3'd3: aluRes = decB;
        3'd4: begin
          wide   = {1'b0, decA} + {1'b0, decB};
          aluRes = wide[15:0];
        end
        3'd5: begin
          wide   = {1'b0, decA} - {1'b0, decB};
          aluRes = wide[15:0];
        end
        3'd6: aluRes = decA & decB;
        default: aluRes = decA | decB;
      endcase
      nextFlags[FZ] = (aluRes == '0);
      nextFlags[FN] = aluRes[15];
      if (decFunc inside {3'd1, 3'd2, 3'd4, 3'd5}) nextFlags[FC] = wide[16];
    end else if (aluOp) begin                      // CLRC / SETC
      nextFlags[FC] = decFunc[0];
    end else if (aluSrc) begin                     // Shift group
      case (decFunc)
        3'd0: begin
          wide   = {1'b0, decB} << decImm[3:0];
          aluRes = wide[15:0];
        end
        3'd1: begin
          wide   = {decB, 1'b0} >> decImm[3:0];
          aluRes = wide[16:1];
        end
        default: aluRes = decImm;                  // LDM leaves the flags
      endcase
      if (decFunc[2:1] == 2'b00) begin
        nextFlags[FZ] = (aluRes == '0);
        nextFlags[FN] = aluRes[15];
        if (decImm[3:0] != 4'd0) nextFlags[FC] = decFunc[0] ? wide[0] : wide[16];
      end
    end
  end

  // Jump conditions on the current flags
  always_comb begin
    case (decFunc)
      3'd0:    cond = 1'b1;                        // JMP
      3'd1:    cond = flags[FN];
      3'd2:    cond = flags[FC];
      3'd3:    cond = flags[FZ];
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) flags <= '0;
    else if (decValid && !hold) flags <= nextFlags;
  end

  always_comb begin
    if (inEn) exValue = inPort;
    else if (memRead || memWrite) exValue = decImm;  // Direct address for LDD / STD
    else exValue = aluRes;
  end

  assign exStore    = pushPc ? (isInt ? decPc : decPc + 1'b1) : decB;
  assign exTarget   = isInt ? `INT_VECTOR : decB;
  assign exTaken    = branch && (pushPc || cond);  // CALL and irq always taken
  assign exValid    = decValid;
  assign exRd       = decRd;
  assign exRegWrite = regWrite;
  assign exMemRead  = memRead;
  assign exMemWrite = memWrite;
  assign exMemToReg = memToReg;
  assign exOutEn    = outEn;
  assign exPush     = push;
  assign exPop      = pop;
  assign exPushPc   = pushPc;
  assign exPopPc    = popPc;
  assign exIsInt    = isInt;
  assign exIsReti   = isReti;

endmodule

//--- hdl/resultStage.sv
// Result stage: data memory and stack, writeback, output credits and redirect reports
`include "core_settings.svh"

module resultStage (
  input  logic            clk,
  input  logic            rstN,
  input  logic            exValid,
  input  corePkg::regIdxT exRd,
  input  corePkg::wordT   exValue,
  input  corePkg::wordT   exStore,
  input  corePkg::wordT   exTarget,
  input  logic            exTaken,
  input  logic            exRegWrite,
  input  logic            exMemRead,
  input  logic            exMemWrite,
  input  logic            exMemToReg,
  input  logic            exOutEn,
  input  logic            exPush,
  input  logic            exPop,
  input  logic            exPushPc,
  input  logic            exPopPc,
  input  logic            exIsInt,
  input  logic            exIsReti,
  input  logic            outCredit,
  output logic            hold,
  output logic            wbEn,
  output corePkg::regIdxT wbIdx,
  output corePkg::wordT   wbData,
  output logic            outValid,
  output corePkg::wordT   outData,
  output logic            redirectValid,
  output corePkg::rdKindT redirectKind,
  output corePkg::wordT   redirectPc
);
  import corePkg::*;

  wordT    mem [`MEM_WORDS];                       // Data and stack
  memAddrT sp;
  creditT  outCnt;
  logic    rValid, rTaken, rRegWrite, rMemRead, rMemWrite, rMemToReg;
  logic    rOutEn, rPush, rPop, rPushPc, rPopPc, rIsInt, rIsReti;
  regIdxT  rRd;
  wordT    rValue, rStore, rTarget, memData;
  memAddrT rdAddr, wrAddr;
  logic    fire;                                   // Instruction retires this cycle

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rValid <= 1'b0;
      {rTaken, rRegWrite, rMemRead, rMemWrite, rMemToReg, rOutEn,
       rPush, rPop, rPushPc, rPopPc, rIsInt, rIsReti} <= '0;
    end else if (!hold) begin
      rValid <= exValid;
      {rTaken, rRegWrite, rMemRead, rMemWrite, rMemToReg, rOutEn,
       rPush, rPop, rPushPc, rPopPc, rIsInt, rIsReti} <=
        {exTaken, exRegWrite, exMemRead, exMemWrite, exMemToReg, exOutEn,
         exPush, exPop, exPushPc, exPopPc, exIsInt, exIsReti};
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      rRd     <= exRd;
      rValue  <= exValue;
      rStore  <= exStore;
      rTarget <= exTarget;
    end
  end

  assign hold = rValid && rOutEn && (outCnt == '0); // OUT waits for a credit
  assign fire = rValid && !hold;

  // Push writes at sp, pop reads above it
  assign wrAddr  = rPush ? sp : rValue[7:0];
  assign rdAddr  = rPop ? memAddrT'(sp + 1'b1) : rValue[7:0];
  assign memData = rMemRead ? mem[rdAddr] : '0;

  always_ff @(posedge clk) begin
    if (fire && rMemWrite) mem[wrAddr] <= rStore;
  end

  always_ff @(posedge clk) begin
    if (!rstN) sp <= memAddrT'(`SP_RESET);
    else if (fire && rPush) sp <= sp - 1'b1;       // Wraps modulo 256
    else if (fire && rPop) sp <= sp + 1'b1;
  end

  assign wbEn   = fire && rRegWrite;
  assign wbIdx  = rRd;
  assign wbData = rMemToReg ? memData : rValue;

  assign outValid = rValid && rOutEn && (outCnt != '0);
  assign outData  = rStore;                        // rs value

  always_ff @(posedge clk) begin
    if (!rstN) outCnt <= creditT'(`OUT_CREDITS);
    else outCnt <= outCnt + creditT'(outCredit) - creditT'(outValid);
  end

  // Redirect report
  assign redirectValid = fire && (rTaken || rPopPc);
  assign redirectPc    = rPopPc ? memData : rTarget;
  always_comb begin
    if (rIsInt) redirectKind = `RD_INT;
    else if (rPopPc) redirectKind = rIsReti ? `RD_RETI : `RD_RET;
    else if (rPushPc) redirectKind = `RD_CALL;
    else redirectKind = `RD_JUMP;
  end

endmodule

//--- hdl/coreTop.sv
// Top level of the execution core; connects decode, execute and result stages
`include "core_settings.svh"

module coreTop (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,
  input  corePkg::opcodeT instrOp,
  input  corePkg::funcT   instrFunc,
  input  corePkg::regIdxT instrRd,
  input  corePkg::regIdxT instrRs,
  input  corePkg::wordT   instrImm,
  input  corePkg::wordT   instrPc,
  input  logic            instrIrq,
  output logic            instrCredit,
  input  corePkg::wordT   inPort,
  input  logic            outCredit,
  output logic            outValid,
  output corePkg::wordT   outData,
  output logic            redirectValid,
  output corePkg::rdKindT redirectKind,
  output corePkg::wordT   redirectPc
);
  import corePkg::*;

  logic   hold, wbEn, decValid, exValid, exTaken;
  regIdxT wbIdx, decRd, exRd;
  wordT   wbData, decA, decB, decImm, decPc, exValue, exStore, exTarget;
  funcT   decFunc;
  logic   aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch, outEn, inEn;
  logic   push, pop, pushPc, popPc, isInt, isReti;
  logic   exRegWrite, exMemRead, exMemWrite, exMemToReg, exOutEn;
  logic   exPush, exPop, exPushPc, exPopPc, exIsInt, exIsReti;

  instrDecode u_decode (.*);                       // Same-named nets throughout

  aluExecute u_execute (.*);

  resultStage u_result (.*);

endmodule

//--- sim/core_chk.sv
// Output-port assertions for the core; bound into coreTop and polled by the testbench monitor
`include "core_settings.svh"

module coreChk (
  input logic          clk,
  input logic          rstN,
  input logic          instrCredit,
  input logic          outValid,
  input corePkg::wordT outData,
  input logic          outCredit,
  input logic          redirectValid
);
  int failCount = 0;                                // Failed assertions so far
  int outstanding;                                  // Words sent, credit not yet back

  always_ff @(posedge clk) begin
    if (!rstN) outstanding <= 0;
    else outstanding <= outstanding + int'(outValid) - int'(outCredit);
  end

  quietAfterReset: assert property (@(posedge clk)
      !rstN |=> (!outValid && !redirectValid && !instrCredit))
    else begin
      failCount++;
      $error("Channel strobe high on the cycle after reset");
    end

  outDataKnown: assert property (@(posedge clk) disable iff (!rstN)
      outValid |-> !$isunknown(outData))
    else begin
      failCount++;
      $error("outData has unknown bits while outValid is high");
    end

  creditBound: assert property (@(posedge clk) disable iff (!rstN)
      outstanding <= `OUT_CREDITS)
    else begin
      failCount++;
      $error("More OUT words outstanding than output credits");
    end

endmodule

bind coreTop coreChk u_chk (.*);

//--- sim/coreTb.sv
// Testbench for coreTop: random beats from a credit-honouring sender, checked against an ISA model
`include "core_settings.svh"

module coreTb;
  import corePkg::*;

  localparam int          NumBeats = 2000;
  localparam int          Phases   = 4;
  localparam logic [31:0] Seed     = 32'h617306ad;

  logic   clk, rstN, instrValid, instrIrq, instrCredit, outCredit, outValid, redirectValid;
  opcodeT instrOp;
  funcT   instrFunc;
  regIdxT instrRd, instrRs;
  wordT   instrImm, instrPc, inPort, outData, redirectPc;
  rdKindT redirectKind;

  wordT        mRegs [8];                          // Model registers
  wordT        mMem [`MEM_WORDS];
  logic        mKnown [`MEM_WORDS];                // Word holds a defined value
  flagsT       mFlags;                             // {Z, N, C}
  memAddrT     mSp;
  wordT        mPc, mNext;
  wordT        expOut [$];
  rdKindT      expKind [$];
  wordT        expPc [$];
  logic [31:0] sendRng = Seed;
  logic [31:0] takeRng;
  int          sent = 0;
  int          returned = 0;                       // instrCredit pulses seen
  int          owed = 0;                           // Absorbed words not yet credited

  coreTop u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic checkOut(input wordT got);
    if (expOut.size() == 0)
      abortRun($sformatf("ERR %0t: OUT word %h arrived with none expected", $time, got));
    else if (got !== expOut[0])
      abortRun($sformatf("ERR %0t: OUT word %h, expected %h", $time, got, expOut[0]));
    else
      expOut.delete(0);
  endtask

  task automatic checkRedirect(input rdKindT kind, input wordT pc);
    if (expKind.size() == 0)
      abortRun($sformatf("ERR %0t: redirect %0d to %h with none expected", $time, kind, pc));
    else if (kind !== expKind[0] || pc !== expPc[0])
      abortRun($sformatf("ERR %0t: redirect %0d to %h, expected %0d to %h",
                         $time, kind, pc, expKind[0], expPc[0]));
    else begin
      expKind.delete(0);
      expPc.delete(0);
    end
  endtask

  function automatic void setZn(input wordT res);
    mFlags[2] = (res == '0);
    mFlags[1] = res[15];
  endfunction

  function automatic void pushWord(input wordT w);
    mMem[mSp]   = w;
    mKnown[mSp] = 1'b1;
    mSp         = mSp - 1'b1;                      // Wraps at 8 bits
  endfunction

  function automatic wordT popWord();
    mSp = mSp + 1'b1;
    return mMem[mSp];
  endfunction

  function automatic void expectRedirect(input rdKindT k, input wordT pc);
    expKind.push_back(k);
    expPc.push_back(pc);
    mNext = pc;                                    // Correct path follows the target
  endfunction

  // ISA model, one beat in send order
  function automatic void applyModel(input opcodeT op, input funcT fn, input regIdxT rd,
                                     input regIdxT rs, input wordT imm, input logic irq);
    wordT a, b, res;
    int   n;
    logic taken;
    a     = mRegs[rd];
    b     = mRegs[rs];
    n     = int'(imm[3:0]);
    mNext = mPc + 1'b1;
    if (irq) begin                                 // Marked instruction is dropped
      pushWord(mPc);
      expectRedirect(`RD_INT, `INT_VECTOR);
    end else begin
      case (op)
        `OP_FLAG: mFlags[0] = fn[0];
        `OP_ALU: begin
          case (fn)
            3'd0: res = ~b;
            3'd1: res = b + 16'd1;
            3'd2: res = b - 16'd1;
            3'd3: res = b;
            3'd4: res = a + b;
            3'd5: res = a - b;
            3'd6: res = a & b;
            default: res = a | b;
          endcase
          if (fn == 3'd1) mFlags[0] = (b == 16'hffff);      // INC carry
          if (fn == 3'd2) mFlags[0] = (b == 16'h0000);      // DEC borrow
          if (fn == 3'd4) mFlags[0] = (int'(a) + int'(b) > 32'hffff);
          if (fn == 3'd5) mFlags[0] = (a < b);
          setZn(res);
          mRegs[rd] = res;
        end
        `OP_OUT: expOut.push_back(b);
        `OP_IN: mRegs[rd] = inPort;
        `OP_SHIFT: begin
          if (fn >= 3'd2) begin
            mRegs[rd] = imm;                       // LDM
          end else begin
            res = (fn == 3'd0) ? (b << n) : (b >> n);
            if (n != 0) mFlags[0] = (fn == 3'd0) ? b[16 - n] : b[n - 1];
            setZn(res);
            mRegs[rd] = res;
          end
        end
        `OP_PUSH: pushWord(b);
        `OP_POP: mRegs[rd] = popWord();
        `OP_JMP: begin
          case (fn)
            3'd0: taken = 1'b1;
            3'd1: taken = mFlags[1];
            3'd2: taken = mFlags[0];
            3'd3: taken = mFlags[2];
            default: taken = 1'b0;
          endcase
          if (taken) expectRedirect(`RD_JUMP, b);
        end
        `OP_CALL: begin
          pushWord(mPc + 1'b1);
          expectRedirect(`RD_CALL, b);
        end
        `OP_RET: expectRedirect(`RD_RET, popWord());
        `OP_RETI: expectRedirect(`RD_RETI, popWord());
        `OP_LDD: mRegs[rd] = mMem[imm[7:0]];
        `OP_STD: begin
          mMem[imm[7:0]]   = b;
          mKnown[imm[7:0]] = 1'b1;
        end
        default: ;                                 // NOP and unused codes
      endcase
    end
    mPc = mNext;
  endfunction

  task automatic sendBeat(input opcodeT op, input funcT fn, input regIdxT rd,
                          input regIdxT rs, input wordT imm, input logic irq);
    @(posedge clk);
    sendRng = xorshift(sendRng);
    while (sent - returned >= `IN_CREDITS || sendRng[1:0] == 2'd0) begin  // No credit or gap
      instrValid <= 1'b0;
      @(posedge clk);
      sendRng = xorshift(sendRng);
    end
    instrValid <= 1'b1;
    instrOp    <= op;
    instrFunc  <= fn;
    instrRd    <= rd;
    instrRs    <= rs;
    instrImm   <= imm;
    instrPc    <= mPc;
    instrIrq   <= irq;
    sent++;
    applyModel(op, fn, rd, rs, imm, irq);
  endtask

  task automatic randomBeat();
    logic [31:0] r, s;
    opcodeT      op;
    funcT        fn;
    wordT        imm;
    sendRng = xorshift(sendRng);
    r       = sendRng;
    sendRng = xorshift(sendRng);
    s       = sendRng;
    op      = opcodeT'(r[3:0]);
    if (r[7:5] == 3'd0) op = `OP_OUT;              // More OUTs to observe state
    fn  = r[10:8];
    imm = s[15:0];
    if (op == `OP_SHIFT) fn = funcT'(r[10:8] % 3);
    if (op == `OP_JMP) fn[2] = 1'b0;
    if (op == `OP_LDD || op == `OP_STD) imm[7:4] = 4'h0;  // Small data window
    if (op == `OP_LDD && !mKnown[imm[7:0]]) op = `OP_STD;
    if ((op == `OP_POP || op == `OP_RET || op == `OP_RETI) && !mKnown[memAddrT'(mSp + 1'b1)])
      op = `OP_PUSH;                               // Pop only defined words
    sendBeat(op, fn, r[13:11], r[16:14], imm, s[20:16] == 5'd0);
  endtask

  task automatic drain();
    @(posedge clk);
    instrValid <= 1'b0;
    while (sent != returned || expOut.size() != 0 || expKind.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);                     // Flush execute and result
  endtask

  always @(posedge clk) begin                      // Output consumer
    if (rstN) begin
      takeRng = xorshift(takeRng);
      if (owed > 0 && takeRng[2:0] < 3'd3) begin   // Random credit delay
        outCredit <= 1'b1;
        owed--;
      end else begin
        outCredit <= 1'b0;
      end
      if (outValid) owed++;
    end
  end

  always @(posedge clk) begin                      // Result monitor
    if (rstN) begin
      if (instrCredit) returned <= returned + 1;
      if (u_dut.u_chk.failCount != 0)
        abortRun("A bound assertion on the core outputs failed");
      else begin
        if (outValid) checkOut(outData);
        if (redirectValid) checkRedirect(redirectKind, redirectPc);
      end
    end
  end

  initial begin                                    // Watchdog
    #(NumBeats * 20 * 10);
    abortRun("Timeout: the core stopped returning credits or results");
  end

  initial begin
    rstN       = 1'b0;
    instrValid = 1'b0;
    instrOp    = '0;
    instrFunc  = '0;
    instrRd    = '0;
    instrRs    = '0;
    instrImm   = '0;
    instrPc    = '0;
    instrIrq   = 1'b0;
    inPort     = '0;
    outCredit  = 1'b0;
    takeRng    = xorshift(Seed);
    mFlags     = '0;
    mSp        = memAddrT'(`SP_RESET);
    mPc        = '0;
    foreach (mKnown[i]) mKnown[i] = 1'b0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    for (int p = 0; p < Phases; p++) begin
      sendRng = xorshift(sendRng);
      inPort <= sendRng[15:0];                     // Fixed for the whole phase
      if (p == 0) begin
        for (int r = 0; r < 8; r++) begin          // LDM gives every register a value
          sendRng = xorshift(sendRng);
          sendBeat(`OP_SHIFT, 3'd2, regIdxT'(r), '0, sendRng[15:0], 1'b0);
        end
      end
      for (int i = 0; i < NumBeats / Phases; i++) randomBeat();
      drain();
    end
    if (returned != sent || expOut.size() != 0 || expKind.size() != 0)
      abortRun($sformatf("Credit pulses %0d do not match %0d beats sent", returned, sent));
    else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- tb.f
+incdir+hdl
hdl/corePkg.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/resultStage.sv
hdl/coreTop.sv
sim/core_chk.sv
sim/coreTb.sv
